// ==== src/uart_regs_pkg.sv ====
package uart_regs_pkg;

  // one bit time in clock cycles, kept short for simulation
  localparam int clks_per_bit = 16;
  localparam int reg_count = 8;

  typedef logic [7:0] byte_t;
  typedef logic [2:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;
  typedef logic [$clog2(clks_per_bit)-1:0] bit_count_t;

  // reply bytes sent back to the host
  localparam byte_t ack_code = 8'h06;
  localparam byte_t nak_code = 8'h15;

  // outcome kind carried on res_if
  typedef logic [1:0] reply_kind_t;
  localparam reply_kind_t kind_ack = 2'd0;
  localparam reply_kind_t kind_data = 2'd1;
  localparam reply_kind_t kind_nak = 2'd2;

endpackage

// ==== src/cmd_if.sv ====
`timescale 1ns/10ps

interface cmd_if;
  import uart_regs_pkg::*;

  logic      valid;
  logic      ready;
  logic      write;
  // command byte had a nonzero bit in 6..3
  logic      bad;
  reg_addr_t addr;
  reg_data_t wdata;

  modport decode (output valid, write, bad, addr, wdata, input ready);
  modport execute (input valid, write, bad, addr, wdata, output ready);

endinterface

// ==== src/res_if.sv ====
`timescale 1ns/10ps

interface res_if;
  import uart_regs_pkg::*;

  logic        valid;
  logic        ready;
  reply_kind_t kind;
  // register value, meaningful for kind_data only
  reg_data_t   rdata;

  modport execute (output valid, kind, rdata, input ready);
  modport result (input valid, kind, rdata, output ready);

endinterface

// ==== src/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rx,
  output uart_regs_pkg::byte_t rx_byte,
  output logic                 rx_strobe
);
  import uart_regs_pkg::*;

  typedef enum logic [1:0] {idle, start, data, stop} rx_state_t;

  rx_state_t  state;
  logic       rx_meta;
  logic       rx_sync;
  bit_count_t count;
  logic [2:0] bit_idx;
  byte_t      shift_reg;

  // two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      count     <= '0;
      bit_idx   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      case (state)
        idle: begin
          count <= '0;
          if (!rx_sync) state <= start;
        end
        start: begin
          // half a bit in, the start bit must still be low
          if (count == bit_count_t'(clks_per_bit / 2 - 1)) begin
            count   <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? idle : data;
          end else begin
            count <= count + 1'b1;
          end
        end
        data: begin
          if (count == bit_count_t'(clks_per_bit - 1)) begin
            count     <= '0;
            shift_reg <= {rx_sync, shift_reg[7:1]};
            bit_idx   <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= stop;
          end else begin
            count <= count + 1'b1;
          end
        end
        stop: begin
          if (count == bit_count_t'(clks_per_bit - 1)) begin
            // low stop bit means a framing error, the byte is dropped
            if (rx_sync) begin
              rx_byte   <= shift_reg;
              rx_strobe <= 1'b1;
            end
            state <= idle;
          end else begin
            count <= count + 1'b1;
          end
        end
      endcase
    end
  end

  a_strobe_single: assert property (@(posedge clk) disable iff (reset)
    rx_strobe |=> !rx_strobe);

endmodule

// ==== src/cmd_decode.sv ====
`timescale 1ns/10ps

module cmd_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_regs_pkg::byte_t rx_byte,
  input  logic                 rx_strobe,
  cmd_if.decode                cmd
);

  typedef enum logic [1:0] {wait_cmd, wait_data, hold} decode_state_t;

  decode_state_t state;
  logic          byte_bad;

  // bits 6..3 must be clear in a command byte
  assign byte_bad = |rx_byte[6:3];
  assign cmd.valid = (state == hold);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= wait_cmd;
    end else begin
      case (state)
        wait_cmd: begin
          if (rx_strobe) begin
            cmd.addr  <= rx_byte[2:0];
            cmd.bad   <= byte_bad;
            cmd.write <= rx_byte[7] & ~byte_bad;
            // only a good write waits for a data byte
            state     <= (rx_byte[7] && !byte_bad) ? wait_data : hold;
          end
        end
        wait_data: begin
          if (rx_strobe) begin
            cmd.wdata <= rx_byte;
            state     <= hold;
          end
        end
        hold: begin
          if (cmd.ready) state <= wait_cmd;
        end
        default: state <= wait_cmd;
      endcase
    end
  end

  // the byte rate leaves room for the reply before the next command byte
  a_no_strobe_in_hold: assert property (@(posedge clk) disable iff (reset)
    !(rx_strobe && state == hold));

  a_payload_stable: assert property (@(posedge clk) disable iff (reset)
    (cmd.valid && !cmd.ready) |=>
      (cmd.valid && $stable({cmd.write, cmd.bad, cmd.addr, cmd.wdata})));

endmodule

// ==== src/reg_execute.sv ====
`timescale 1ns/10ps

module reg_execute (
  input  logic   clk,
  input  logic   reset,
  cmd_if.execute cmd,
  res_if.execute res
);
  import uart_regs_pkg::*;

  reg_data_t regs [reg_count];
  logic      slot_full;
  logic      cmd_xfer;

  // one-entry result slot takes a new command only when empty
  assign cmd.ready = !slot_full;
  assign res.valid = slot_full;
  assign cmd_xfer = cmd.valid && cmd.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_full <= 1'b0;
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (cmd_xfer) begin
      slot_full <= 1'b1;
      // decode clears write for a malformed command byte
      if (cmd.write) regs[cmd.addr] <= cmd.wdata;
    end else if (res.valid && res.ready) begin
      slot_full <= 1'b0;
    end
  end

  // outcome payload
  always_ff @(posedge clk) begin
    if (cmd_xfer) begin
      res.rdata <= regs[cmd.addr];
      if (cmd.bad) res.kind <= kind_nak;
      else if (cmd.write) res.kind <= kind_ack;
      else res.kind <= kind_data;
    end
  end

  a_bad_no_write: assert property (@(posedge clk) disable iff (reset)
    (cmd_xfer && cmd.bad) |=> (regs[$past(cmd.addr)] == $past(regs[cmd.addr])));

endmodule

// ==== src/reply_format.sv ====
`timescale 1ns/10ps

module reply_format (
  input  logic                 clk,
  input  logic                 reset,
  res_if.result                res,
  output uart_regs_pkg::byte_t tx_byte,
  output logic                 tx_valid,
  input  logic                 tx_ready
);
  import uart_regs_pkg::*;

  // a held byte blocks the next outcome
  assign res.ready = !tx_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid <= 1'b0;
    end else if (res.valid && res.ready) begin
      tx_valid <= 1'b1;
    end else if (tx_valid && tx_ready) begin
      tx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (res.valid && res.ready) begin
      case (res.kind)
        kind_ack:  tx_byte <= ack_code;
        kind_data: tx_byte <= res.rdata;
        default:   tx_byte <= nak_code;
      endcase
    end
  end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_regs_pkg::byte_t tx_byte,
  input  logic                 tx_valid,
  output logic                 tx_ready,
  output logic                 tx
);
  import uart_regs_pkg::*;

  typedef enum logic [1:0] {idle, start, data, stop} tx_state_t;

  tx_state_t  state;
  bit_count_t count;
  logic [2:0] bit_idx;
  byte_t      shift_reg;
  logic       bit_done;

  assign bit_done = (count == bit_count_t'(clks_per_bit - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      count    <= '0;
      bit_idx  <= '0;
      tx_ready <= 1'b1;
      tx       <= 1'b1;
    end else begin
      count <= bit_done ? '0 : count + 1'b1;
      case (state)
        idle: begin
          count <= '0;
          // start bit goes out right after the transfer
          if (tx_valid && tx_ready) begin
            shift_reg <= tx_byte;
            tx_ready  <= 1'b0;
            tx        <= 1'b0;
            state     <= start;
          end
        end
        start: begin
          if (bit_done) begin
            tx        <= shift_reg[0];
            shift_reg <= {1'b0, shift_reg[7:1]};
            bit_idx   <= '0;
            state     <= data;
          end
        end
        data: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;
              state <= stop;
            end else begin
              tx        <= shift_reg[0];
              shift_reg <= {1'b0, shift_reg[7:1]};
              bit_idx   <= bit_idx + 1'b1;
            end
          end
        end
        stop: begin
          if (bit_done) begin
            tx_ready <= 1'b1;
            state    <= idle;
          end
        end
      endcase
    end
  end

  a_idle_high: assert property (@(posedge clk) disable iff (reset)
    (state == idle) |-> tx);

endmodule

// ==== src/uart_regs_top.sv ====
`timescale 1ns/10ps

module uart_regs_top (
  input  logic clk,
  input  logic reset,
  input  logic rx,
  output logic tx
);
  import uart_regs_pkg::*;

  byte_t rx_byte;
  logic  rx_strobe;
  byte_t tx_byte;
  logic  tx_valid;
  logic  tx_ready;

  cmd_if cmd_bus ();
  res_if res_bus ();

  // rx line to bytes
  uart_rx rx_i (
    .clk       (clk),
    .reset     (reset),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe)
  );

  cmd_decode decode_i (
    .clk       (clk),
    .reset     (reset),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .cmd       (cmd_bus.decode)
  );

  reg_execute execute_i (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd_bus.execute),
    .res   (res_bus.execute)
  );

  // one reply byte per command
  reply_format reply_i (
    .clk      (clk),
    .reset    (reset),
    .res      (res_bus.result),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

  uart_tx tx_i (
    .clk      (clk),
    .reset    (reset),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

endmodule

// ==== verification/tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker (
  input logic clk,
  input logic reset,
  input logic tx
);
  import uart_regs_pkg::*;

  localparam int reply_timeout = 40 * clks_per_bit;

  string name_q [$];
  byte_t exp_q [$];
  int    done_count = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  logic  idle_window = 1'b0;

  task automatic push_expect(input string name, input byte_t exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  // tx must stay high for the given number of bit times
  task automatic check_idle(input string name, input int bits);
    logic seen_low;
    seen_low = 1'b0;
    idle_window = 1'b1;
    for (int i = 0; i < bits * clks_per_bit; i++) begin
      @(posedge clk);
      if (tx !== 1'b1) seen_low = 1'b1;
    end
    idle_window = 1'b0;
    if (seen_low) begin
      $display("FAILED %s expected tx 1 actual 0", name);
      fail_count++;
    end else begin
      $display("passed %s", name);
      pass_count++;
    end
  endtask

  task automatic receive_reply();
    string      name;
    byte_t      exp;
    logic [7:0] got;
    int         waited;
    name = name_q.pop_front();
    exp = exp_q.pop_front();
    waited = 0;
    while (tx !== 1'b0 && waited < reply_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("%s: no reply arrived within 40 bit times", name);
      fail_count++;
    end else begin
      // move to mid-bit, then one sample per bit time
      repeat (clks_per_bit / 2) @(posedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(posedge clk);
        got[i] = tx;
      end
      repeat (clks_per_bit) @(posedge clk);
      if (tx !== 1'b1) begin
        $display("%s: reply frame has a low stop bit", name);
        fail_count++;
      end else if (got !== exp) begin
        $display("FAILED %s expected 0x%02h actual 0x%02h", name, exp, got);
        fail_count++;
      end else begin
        $display("passed %s 0x%02h", name, got);
        pass_count++;
      end
    end
    done_count++;
  endtask

  always begin
    @(posedge clk);
    if (exp_q.size() != 0) begin
      receive_reply();
    end else if (!reset && !idle_window && tx === 1'b0) begin
      $display("tx sent a start bit while no reply was expected");
      fail_count++;
      repeat (10 * clks_per_bit) @(posedge clk);
    end
  end

  task automatic print_counts();
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
  endtask

endmodule

// ==== verification/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;
  import uart_regs_pkg::*;

  localparam int max_rows = 96;

  logic        clk;
  logic        reset;
  logic        rx;
  logic        tx;
  string       t_name [max_rows];
  byte_t       t_cmd [max_rows];
  byte_t       t_data [max_rows];
  logic        t_has_data [max_rows];
  byte_t       t_exp [max_rows];
  // next command follows right after this one, without waiting for the reply
  logic        t_b2b [max_rows];
  int          row_count;
  reg_data_t   ref_regs [reg_count];
  logic [31:0] lfsr_state;
  int          pushed;
  logic        timed_out;

  uart_regs_top dut_i (.clk(clk), .reset(reset), .rx(rx), .tx(tx));
  tb_checker chk_i (.clk(clk), .reset(reset), .tx(tx));

  always #10 clk = ~clk;

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic byte_t random_bits(input int n);
    byte_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic add_row(input string name, input byte_t cmd, input logic has_data,
                         input byte_t data, input byte_t exp, input logic b2b);
    t_name[row_count] = name;
    t_cmd[row_count] = cmd;
    t_has_data[row_count] = has_data;
    t_data[row_count] = data;
    t_exp[row_count] = exp;
    t_b2b[row_count] = b2b;
    row_count++;
  endtask

  task automatic add_write(input string name, input reg_addr_t a, input byte_t d,
                           input logic b2b);
    add_row(name, {5'b10000, a}, 1'b1, d, ack_code, b2b);
    ref_regs[a] = d;
  endtask

  task automatic add_read(input string name, input reg_addr_t a, input logic b2b);
    add_row(name, {5'b00000, a}, 1'b0, 8'h00, ref_regs[a], b2b);
  endtask

  task automatic build_table();
    reg_addr_t a;
    byte_t     d;
    for (int i = 0; i < reg_count; i++) begin
      add_read($sformatf("reset_read_%0d", i), reg_addr_t'(i), 1'b0);
    end
    // a distinct value in each register
    for (int i = 0; i < reg_count; i++) begin
      add_write($sformatf("write_%0d", i), reg_addr_t'(i), byte_t'(8'h21 * (i + 1)), 1'b0);
    end
    for (int i = 0; i < reg_count; i++) begin
      add_read($sformatf("read_back_%0d", i), reg_addr_t'(i), 1'b0);
    end
    // write form with one of bits 6..3 set, no data byte follows
    for (int k = 0; k < 4; k++) begin
      a = reg_addr_t'(k + 1);
      add_row($sformatf("bad_bit%0d", k + 3), byte_t'(8'h80 | (8'h08 << k) | {5'b0, a}),
              1'b0, 8'h00, nak_code, 1'b0);
      add_read($sformatf("after_bad_%0d", k + 3), a, 1'b0);
    end
    add_row("bad_read_form", {5'b01111, 3'd5}, 1'b0, 8'h00, nak_code, 1'b0);
    add_read("after_bad_read_form", 3'd5, 1'b0);
    add_write("b2b_write_2", 3'd2, 8'ha5, 1'b1);
    add_read("b2b_read_2", 3'd2, 1'b1);
    add_row("b2b_bad", 8'h4a, 1'b0, 8'h00, nak_code, 1'b1);
    add_read("b2b_read_7", 3'd7, 1'b0);
    for (int i = 0; i < 40; i++) begin
      a = reg_addr_t'(random_bits(3));
      if (random_bits(1) == 8'd1) begin
        d = random_bits(8);
        add_write($sformatf("rand_write_%0d", i), a, d, 1'b0);
      end else begin
        add_read($sformatf("rand_read_%0d", i), a, 1'b0);
      end
    end
  endtask

  task automatic send_bit(input logic v);
    @(posedge clk);
    rx <= v;
    repeat (clks_per_bit - 1) @(posedge clk);
  endtask

  // 8N1 frame, lsb first
  task automatic send_byte(input byte_t b);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      send_bit(b[i]);
    end
    send_bit(1'b1);
  endtask

  task automatic wait_replies();
    int waited;
    waited = 0;
    while (chk_i.done_count != pushed && waited < 60 * clks_per_bit) begin
      @(posedge clk);
      waited++;
    end
    if (chk_i.done_count != pushed) begin
      $display("timeout: checker still busy after %0d commands", pushed);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    rx = 1'b1;
    lfsr_state = 32'h7491bf1a;
    row_count = 0;
    pushed = 0;
    timed_out = 1'b0;
    for (int i = 0; i < reg_count; i++) begin
      ref_regs[i] = '0;
    end
    build_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    chk_i.check_idle("idle_tx", 20);
    for (int r = 0; r < row_count && !timed_out; r++) begin
      // expectation goes in before the last byte, the reply can start inside its stop bit
      if (!t_has_data[r]) chk_i.push_expect(t_name[r], t_exp[r]);
      send_byte(t_cmd[r]);
      if (t_has_data[r]) begin
        chk_i.push_expect(t_name[r], t_exp[r]);
        send_byte(t_data[r]);
      end
      pushed++;
      if (!t_b2b[r]) wait_replies();
    end
    chk_i.print_counts();
    if (!timed_out && chk_i.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/uart_regs_pkg.sv
src/cmd_if.sv
src/res_if.sv
src/uart_rx.sv
src/cmd_decode.sv
src/reg_execute.sv
src/reply_format.sv
src/uart_tx.sv
src/uart_regs_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
